//--- gemm_ctrl.f
+incdir+include
hdl/gemm_pkg.sv
hdl/tile_if.sv
hdl/tile_sequencer.sv
hdl/sram_addr_gen.sv
hdl/skew_enable_gen.sv
hdl/gemm_ctrl.sv
sim/gemm_ctrl_asserts.sv
sim/tb_gemm_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the gemm_ctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        -f gemm_ctrl.f --top-module tb_gemm_ctrl --Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_gemm_ctrl 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^RESULT: PASS$"; then
    exit 0
fi

echo "Pass line not found in simulation output"
exit 1

//--- sim/gemm_trace.txt
# One job per line, decimal
# M K N expected_tiles expected_out_we_cycles
4 4 4 1 4
1 1 1 1 1
8 3 8 4 16
5 2 7 4 10
3 5 9 3 9
12 1 4 3 12
7 6 6 4 14
16 2 13 16 64
2 9 3 1 2
9 4 5 6 18

//--- sim/tb_gemm_ctrl.sv
`timescale 1ns/1ps
`include "gemm_defines.svh"

module tb_gemm_ctrl;

    localparam int PR = `PE_ROWS;
    localparam int PC = `PE_COLS;

    logic          CLK;
    logic          RSTn;
    logic          START;
    logic [5:0]    m_size;
    logic [5:0]    k_size;
    logic [5:0]    n_size;
    logic [7:0]    opnd1_addr;
    logic [7:0]    opnd2_addr;
    logic [7:0]    out_addr;
    logic          out_we;
    logic [PC-1:0] out_col_mask;
    logic [PR-1:0] opnd1_push;
    logic [PR-1:0] opnd1_pop;
    logic [PC-1:0] opnd2_push;
    logic [PC-1:0] opnd2_pop;
    logic          computing;
    logic          flushing;
    logic          finished;

    int            errors;
    int            cycles;
    int            jobs;
    logic          timed_out;
    logic [31:0]   rng;
    int            seen_tiles;      // Flush entries seen in the current job
    int            seen_writes;
    logic          prev_flushing;

    gemm_ctrl uut (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Lane i pops for K cycles from count i, seen one cycle late
    function automatic logic [7:0] expect_pop(input int c, input int k, input int lanes);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < lanes; i++) begin
            if (c > 0 && c - 1 >= i && c - 1 < k + i) v[i] = 1'b1;
        end
        return v;
    endfunction

    task automatic report_mismatch(input string name, input int exp, input int act);
        errors++;
        $display("Fail time=%0t signal=%s expected=0x%0h actual=0x%0h", $time, name, exp, act);
    endtask

    task automatic note_activity();
        cycles++;
        if (flushing && !prev_flushing) seen_tiles++;
        if (out_we) seen_writes++;
        prev_flushing = flushing;
    endtask

    task automatic check_compute(input int r, input int q, input int c, input int ntr,
                                 input int ntc, input int k);
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] pu;
        logic [7:0] po1;
        logic [7:0] po2;
        a1  = 8'(r + c * ntr);
        a2  = 8'(q + c * ntc);
        pu  = (c > 0 && c - 1 < k) ? 8'hff : 8'h00;  // Every lane pushes for K cycles
        po1 = expect_pop(c, k, PR);
        po2 = expect_pop(c, k, PC);
        if (computing !== 1'b1) report_mismatch("computing", 1, computing);
        if (flushing !== 1'b0) report_mismatch("flushing", 0, flushing);
        if (finished !== 1'b0) report_mismatch("finished", 0, finished);
        if (out_we !== 1'b0) report_mismatch("out_we", 0, out_we);
        if (opnd1_addr !== a1) report_mismatch("opnd1_addr", a1, opnd1_addr);
        if (opnd2_addr !== a2) report_mismatch("opnd2_addr", a2, opnd2_addr);
        if (opnd1_push !== pu[PR-1:0]) report_mismatch("opnd1_push", pu[PR-1:0], opnd1_push);
        if (opnd2_push !== pu[PC-1:0]) report_mismatch("opnd2_push", pu[PC-1:0], opnd2_push);
        if (opnd1_pop !== po1[PR-1:0]) report_mismatch("opnd1_pop", po1[PR-1:0], opnd1_pop);
        if (opnd2_pop !== po2[PC-1:0]) report_mismatch("opnd2_pop", po2[PC-1:0], opnd2_pop);
        note_activity();
    endtask

    task automatic check_flush(input int r, input int q, input int f, input int ntc,
                               input int ar, input int ac, input logic last);
        logic [7:0] wa;
        logic [7:0] mask;
        logic       we;
        logic       fin;
        wa   = 8'(r * ntc * PR + ntc * (PR - 1) + q - f * ntc);   // Bottom row first
        mask = 8'((1 << ac) - 1);
        we   = (f >= PR - ar);
        fin  = last && (f == PR - 1);
        if (flushing !== 1'b1) report_mismatch("flushing", 1, flushing);
        if (computing !== 1'b0) report_mismatch("computing", 0, computing);
        if (finished !== fin) report_mismatch("finished", fin, finished);
        if (out_we !== we) report_mismatch("out_we", we, out_we);
        if (out_addr !== wa) report_mismatch("out_addr", wa, out_addr);
        if (out_col_mask !== mask[PC-1:0]) report_mismatch("out_col_mask", mask, out_col_mask);
        if (opnd1_push !== '0) report_mismatch("opnd1_push", 0, opnd1_push);
        if (opnd2_push !== '0) report_mismatch("opnd2_push", 0, opnd2_push);
        if (opnd1_pop !== '0) report_mismatch("opnd1_pop", 0, opnd1_pop);
        if (opnd2_pop !== '0) report_mismatch("opnd2_pop", 0, opnd2_pop);
        note_activity();
    endtask

    task automatic check_idle();
        if (computing !== 1'b0) report_mismatch("computing", 0, computing);
        if (flushing !== 1'b0) report_mismatch("flushing", 0, flushing);
        if (finished !== 1'b0) report_mismatch("finished", 0, finished);
        if (out_we !== 1'b0) report_mismatch("out_we", 0, out_we);
        if (opnd1_pop !== '0) report_mismatch("opnd1_pop", 0, opnd1_pop);
        if (opnd2_pop !== '0) report_mismatch("opnd2_pop", 0, opnd2_pop);
    endtask

    task automatic run_job(input int m, input int k, input int n, input int gap,
                           input int exp_tiles, input int exp_writes);
        int   ntr;
        int   ntc;
        int   ar;
        int   ac;
        int   len;
        int   waited;
        int   errors_before;
        logic last;
        ntr           = (m + PR - 1) / PR;
        ntc           = (n + PC - 1) / PC;
        errors_before = errors;
        seen_tiles    = 0;
        seen_writes   = 0;
        prev_flushing = 1'b0;
        repeat (gap) @(posedge CLK);
        #1;
        START  = 1'b1;
        m_size = 6'(m);
        k_size = 6'(k);
        n_size = 6'(n);
        @(posedge CLK);
        #1;
        START  = 1'b0;
        waited = 0;
        @(negedge CLK);
        // Compute starts in the cycle right after the START edge
        if (computing !== 1'b1) report_mismatch("computing", 1, computing);
        while (computing !== 1'b1 && waited < 16) begin
            @(negedge CLK);
            waited++;
        end
        if (computing !== 1'b1) begin
            $display("Timeout: computing never rose after START of job %0d", jobs);
            timed_out = 1'b1;
            return;
        end
        for (int r = 0; r < ntr; r++) begin
            for (int q = 0; q < ntc; q++) begin
                ar   = (m - r * PR < PR) ? m - r * PR : PR;
                ac   = (n - q * PC < PC) ? n - q * PC : PC;
                len  = k + ar + ac;
                last = (r == ntr - 1) && (q == ntc - 1);
                for (int c = 0; c < len; c++) begin
                    if (r != 0 || q != 0 || c != 0) @(negedge CLK);
                    check_compute(r, q, c, ntr, ntc, k);
                    if (r == 0 && q == 0 && c == 1) begin
                        @(posedge CLK);
                        #1;
                        START  = 1'b1;  // Busy START with other sizes
                        m_size = 6'd63;
                        k_size = 6'd63;
                        n_size = 6'd63;
                    end else if (r == 0 && q == 0 && c == 2) begin
                        @(posedge CLK);
                        #1;
                        START = 1'b0;
                    end
                end
                for (int f = 0; f < PR; f++) begin
                    @(negedge CLK);
                    check_flush(r, q, f, ntc, ar, ac, last);
                end
            end
        end
        @(negedge CLK);
        check_idle();
        if (seen_tiles != exp_tiles) report_mismatch("tile_count", exp_tiles, seen_tiles);
        if (seen_writes != exp_writes) report_mismatch("out_we_count", exp_writes, seen_writes);
        jobs++;
        $display("Job %0d M=%0d K=%0d N=%0d tiles=%0d writes=%0d %s", jobs, m, k, n,
                 seen_tiles, seen_writes, (errors == errors_before) ? "ok" : "mismatch");
    endtask

    initial begin
        string line;
        int    fd;
        int    m;
        int    k;
        int    n;
        int    exp_tiles;
        int    exp_writes;
        int    gap;
        errors    = 0;
        cycles    = 0;
        jobs      = 0;
        timed_out = 1'b0;
        rng       = 32'h12e652c6;
        RSTn      = 1'b0;
        START     = 1'b0;
        m_size    = '0;
        k_size    = '0;
        n_size    = '0;
        repeat (3) @(posedge CLK);
        #1;
        RSTn = 1'b1;
        @(negedge CLK);
        check_idle();
        if ({opnd1_addr, opnd2_addr, out_addr, out_col_mask} !== '0)
            report_mismatch("reset_outputs", 0, {opnd1_addr, opnd2_addr, out_addr, out_col_mask});
        if ({opnd1_push, opnd2_push} !== '0)
            report_mismatch("reset_push", 0, {opnd1_push, opnd2_push});
        fd = $fopen("sim/gemm_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file sim/gemm_trace.txt");
            errors++;
        end else begin
            while (!timed_out && !$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0) begin
                    if ($sscanf(line, "%d %d %d %d %d", m, k, n, exp_tiles, exp_writes) == 5) begin
                        rng = xorshift32(rng);
                        gap = 1 + int'(rng % 4);    // Idle cycles before START
                        run_job(m, k, n, gap, exp_tiles, exp_writes);
                    end
                end
            end
            $fclose(fd);
        end
        if (jobs == 0) begin
            $display("No job was run from the trace file");
            errors++;
        end
        $display("Summary: jobs=%0d cycles_checked=%0d errors=%0d timeout=%0d",
                 jobs, cycles, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sim/gemm_ctrl_asserts.sv
`timescale 1ns/1ps
`include "gemm_defines.svh"

module gemm_ctrl_asserts (
    input logic                CLK,
    input logic                RSTn,
    input logic                computing,
    input logic                flushing,
    input logic                finished,
    input logic                out_we,
    input logic [`PE_COLS-1:0] out_col_mask,
    input logic [`PE_ROWS-1:0] opnd1_pop,
    input logic [`PE_COLS-1:0] opnd2_pop
);

    // One phase at a time
    a_phase_excl: assert property (@(posedge CLK) disable iff (!RSTn)
        !(computing && flushing))
        else $error("computing and flushing are high together");

    // Last flush cycle of the job, idle right after
    a_finished_in_flush: assert property (@(posedge CLK) disable iff (!RSTn)
        finished |-> flushing ##1 (!flushing && !computing))
        else $error("finished is outside flush or not followed by idle");

    // FIFO pops only while the array computes
    a_pop_in_compute: assert property (@(posedge CLK) disable iff (!RSTn)
        !computing |-> (opnd1_pop == '0 && opnd2_pop == '0))
        else $error("operand pop enable set outside compute");

    a_we_in_flush: assert property (@(posedge CLK) disable iff (!RSTn)
        out_we |-> (flushing && out_col_mask != '0))
        else $error("out_we is high outside flush or with no column enabled");

endmodule

bind gemm_ctrl gemm_ctrl_asserts u_asserts (
    .CLK         (CLK),
    .RSTn        (RSTn),
    .computing   (computing),
    .flushing    (flushing),
    .finished    (finished),
    .out_we      (out_we),
    .out_col_mask(out_col_mask),
    .opnd1_pop   (opnd1_pop),
    .opnd2_pop   (opnd2_pop)
);

//--- hdl/gemm_ctrl.sv
`timescale 1ns/1ps
`include "gemm_defines.svh"

module gemm_ctrl (
    input  logic                  CLK,
    input  logic                  RSTn,
    input  logic                  START,
    input  gemm_pkg::m_size_t     m_size,
    input  gemm_pkg::k_size_t     k_size,
    input  gemm_pkg::n_size_t     n_size,
    output gemm_pkg::opnd1_addr_t opnd1_addr,
    output gemm_pkg::opnd2_addr_t opnd2_addr,
    output gemm_pkg::out_addr_t   out_addr,
    output logic                  out_we,
    output logic [`PE_COLS-1:0]   out_col_mask,
    output logic [`PE_ROWS-1:0]   opnd1_push,
    output logic [`PE_ROWS-1:0]   opnd1_pop,
    output logic [`PE_COLS-1:0]   opnd2_push,
    output logic [`PE_COLS-1:0]   opnd2_pop,
    output logic                  computing,
    output logic                  flushing,
    output logic                  finished
);
    import gemm_pkg::*;

    actv_row_t  actv_rows;
    actv_col_t  actv_cols;
    phase_cnt_t flush_count;

    tile_if u_tile ();

    tile_sequencer u_seq (
        .CLK        (CLK),
        .RSTn       (RSTn),
        .start      (START),
        .m_size_in  (m_size),
        .k_size_in  (k_size),
        .n_size_in  (n_size),
        .tile       (u_tile.seq),
        .flushing   (flushing),
        .finished   (finished),
        .actv_rows  (actv_rows),
        .actv_cols  (actv_cols),
        .flush_count(flush_count)
    );

    sram_addr_gen u_addr (
        .CLK       (CLK),
        .RSTn      (RSTn),
        .tile      (u_tile.addr),
        .opnd1_addr(opnd1_addr),
        .opnd2_addr(opnd2_addr),
        .out_addr  (out_addr)
    );

    skew_enable_gen #(.LANES(`PE_ROWS)) u_opnd1_lanes (
        .CLK (CLK),
        .RSTn(RSTn),
        .tile(u_tile.lanes),
        .push(opnd1_push),
        .pop (opnd1_pop)
    );

    skew_enable_gen #(.LANES(`PE_COLS)) u_opnd2_lanes (
        .CLK (CLK),
        .RSTn(RSTn),
        .tile(u_tile.lanes),
        .push(opnd2_push),
        .pop (opnd2_pop)
    );

    // Only the last ar flush cycles carry live rows
    assign out_we = flushing
                 && ((flush_count + phase_cnt_t'(actv_rows)) >= phase_cnt_t'(`PE_ROWS));

    for (genvar j = 0; j < `PE_COLS; j++) begin : g_col_mask
        assign out_col_mask[j] = (actv_cols > actv_col_t'(j));
    end

    assign computing = u_tile.computing;

endmodule

//--- hdl/skew_enable_gen.sv
`timescale 1ns/1ps

module skew_enable_gen #(
    parameter int LANES = 4
) (
    input  logic             CLK,
    input  logic             RSTn,
    tile_if.lanes            tile,
    output logic [LANES-1:0] push,
    output logic [LANES-1:0] pop
);
    import gemm_pkg::*;

    logic [LANES-1:0] push_nxt;
    logic [LANES-1:0] pop_nxt;
    phase_cnt_t       k_ext;
    logic             live;

    assign k_ext = phase_cnt_t'(tile.k_size);

    // Nothing carries over into flush
    assign live = tile.computing && !tile.flush_enter;

    // Lane i pops from count i for K cycles, the diagonal wavefront
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        assign push_nxt[i] = live && (tile.compute_count < k_ext);
        assign pop_nxt[i]  = live
                           && (tile.compute_count >= phase_cnt_t'(i))
                           && (tile.compute_count < k_ext + phase_cnt_t'(i));
    end

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            push <= '0;
            pop  <= '0;
        end else begin
            push <= push_nxt;
            pop  <= pop_nxt;
        end
    end

endmodule

//--- hdl/sram_addr_gen.sv
`timescale 1ns/1ps
`include "gemm_defines.svh"

module sram_addr_gen (
    input  logic                  CLK,
    input  logic                  RSTn,
    tile_if.addr                  tile,
    output gemm_pkg::opnd1_addr_t opnd1_addr,
    output gemm_pkg::opnd2_addr_t opnd2_addr,
    output gemm_pkg::out_addr_t   out_addr
);
    import gemm_pkg::*;

    out_addr_t   row_offset;    // First output entry of the current tile row
    out_addr_t   ntc;
    out_addr_t   row_span;
    out_addr_t   flush_base;
    opnd1_addr_t opnd1_stride;
    opnd2_addr_t opnd2_stride;

    // Operand 1 is column-major, operand 2 and the output are row-major
    assign opnd1_stride = opnd1_addr_t'(tile.num_tile_rows);
    assign opnd2_stride = opnd2_addr_t'(tile.num_tile_cols);

    assign ntc      = out_addr_t'(tile.num_tile_cols);
    assign row_span = ntc << `PE_ROWS_LOG2;

    // Bottom row of the tile is written first
    assign flush_base = row_offset + row_span - ntc + out_addr_t'(tile.tile_col_id);

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            opnd1_addr <= '0;
            opnd2_addr <= '0;
            row_offset <= '0;
        end else if (tile.job_load) begin
            opnd1_addr <= '0;   // First tile is always (0, 0)
            opnd2_addr <= '0;
            row_offset <= '0;
        end else if (tile.tile_load) begin
            opnd1_addr <= opnd1_addr_t'(tile.tile_row_id);
            opnd2_addr <= opnd2_addr_t'(tile.tile_col_id);
            if (tile.row_wrap) begin
                row_offset <= row_offset + row_span;
            end
        end else if (tile.computing) begin
            opnd1_addr <= opnd1_addr + opnd1_stride;
            opnd2_addr <= opnd2_addr + opnd2_stride;
        end
    end

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            out_addr <= '0;
        end else if (tile.flush_enter) begin
            out_addr <= flush_base;
        end else if (tile.flush_step) begin
            out_addr <= out_addr - ntc;     // One row up
        end
    end

endmodule

//--- hdl/tile_sequencer.sv
`timescale 1ns/1ps
`include "gemm_defines.svh"

module tile_sequencer (
    input  logic                 CLK,
    input  logic                 RSTn,
    input  logic                 start,
    input  gemm_pkg::m_size_t    m_size_in,
    input  gemm_pkg::k_size_t    k_size_in,
    input  gemm_pkg::n_size_t    n_size_in,
    tile_if.seq                  tile,
    output logic                 flushing,
    output logic                 finished,
    output gemm_pkg::actv_row_t  actv_rows,
    output gemm_pkg::actv_col_t  actv_cols,
    output gemm_pkg::phase_cnt_t flush_count
);
    import gemm_pkg::*;

    localparam int MW = `MAX_M_LOG2 + 2;  // Room for id << log2
    localparam int NW = `MAX_N_LOG2 + 2;

    typedef enum logic [1:0] {IDLE, COMPUTE, FLUSH} state_t;

    state_t     state;

    // Job registers, loaded at START
    m_size_t    m_size;
    k_size_t    k_size;
    n_size_t    n_size;
    tile_row_t  num_rows;
    tile_col_t  num_cols;

    tile_row_t  row_id;
    tile_col_t  col_id;
    phase_cnt_t compute_count;
    logic       row_wrap;
    logic       last_tile;

    logic       idle;
    logic       compute_done;
    logic       flush_done;
    logic       col_end;
    phase_cnt_t compute_end;
    m_size_t    sel_m;
    n_size_t    sel_n;
    tile_row_t  sel_row;
    tile_col_t  sel_col;
    logic [MW-1:0] rows_left;
    logic [NW-1:0] cols_left;
    actv_row_t  actv_rows_nxt;
    actv_col_t  actv_cols_nxt;

    assign idle = (state == IDLE);

    assign compute_end = phase_cnt_t'(k_size) + phase_cnt_t'(actv_rows)
                       + phase_cnt_t'(actv_cols) - 1'b1;
    assign compute_done = (state == COMPUTE) && (compute_count == compute_end);
    assign flush_done   = (state == FLUSH) && (flush_count == phase_cnt_t'(`PE_ROWS - 1));
    assign col_end      = (col_id == num_cols - 1'b1);

    // Ids already point at the next tile during flush, so one formula serves both entries
    assign sel_m   = idle ? m_size_in : m_size;
    assign sel_n   = idle ? n_size_in : n_size;
    assign sel_row = idle ? '0 : row_id;
    assign sel_col = idle ? '0 : col_id;

    assign rows_left = MW'(sel_m) - (MW'(sel_row) << `PE_ROWS_LOG2);
    assign cols_left = NW'(sel_n) - (NW'(sel_col) << `PE_COLS_LOG2);
    assign actv_rows_nxt = (rows_left >= MW'(`PE_ROWS)) ? actv_row_t'(`PE_ROWS)
                                                        : actv_row_t'(rows_left);
    assign actv_cols_nxt = (cols_left >= NW'(`PE_COLS)) ? actv_col_t'(`PE_COLS)
                                                        : actv_col_t'(cols_left);

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            state         <= IDLE;
            row_id        <= '0;
            col_id        <= '0;
            compute_count <= '0;
            flush_count   <= '0;
            actv_rows     <= '0;
            actv_cols     <= '0;
            row_wrap      <= 1'b0;
            last_tile     <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state         <= COMPUTE;
                        m_size        <= m_size_in;
                        k_size        <= k_size_in;
                        n_size        <= n_size_in;
                        num_rows      <= tile_row_t'(tiles_needed(m_size_in, `PE_ROWS_LOG2));
                        num_cols      <= tile_col_t'(tiles_needed(n_size_in, `PE_COLS_LOG2));
                        row_id        <= '0;
                        col_id        <= '0;
                        actv_rows     <= actv_rows_nxt;
                        actv_cols     <= actv_cols_nxt;
                        compute_count <= '0;
                        row_wrap      <= 1'b0;
                        last_tile     <= 1'b0;
                    end
                end
                COMPUTE: begin
                    if (compute_done) begin
                        state         <= FLUSH;
                        compute_count <= '0;
                        flush_count   <= '0;
                        // Step to the next tile, column id fastest
                        last_tile     <= col_end && (row_id == num_rows - 1'b1);
                        row_wrap      <= col_end;
                        if (col_end) begin
                            col_id <= '0;
                            row_id <= row_id + 1'b1;
                        end else begin
                            col_id <= col_id + 1'b1;
                        end
                    end else begin
                        compute_count <= compute_count + 1'b1;
                    end
                end
                FLUSH: begin
                    if (flush_done) begin
                        flush_count <= '0;
                        if (last_tile) begin
                            state     <= IDLE;
                            actv_rows <= '0;
                            actv_cols <= '0;
                        end else begin
                            state     <= COMPUTE;
                            actv_rows <= actv_rows_nxt;
                            actv_cols <= actv_cols_nxt;
                        end
                    end else begin
                        flush_count <= flush_count + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign tile.job_load      = idle && start;
    assign tile.tile_load     = (idle && start) || (flush_done && !last_tile);
    assign tile.flush_enter   = compute_done;
    assign tile.flush_step    = (state == FLUSH) && !flush_done;
    assign tile.row_wrap      = row_wrap;
    assign tile.computing     = (state == COMPUTE);
    assign tile.compute_count = compute_count;
    assign tile.tile_row_id   = row_id;
    assign tile.tile_col_id   = col_id;
    assign tile.num_tile_rows = num_rows;
    assign tile.num_tile_cols = num_cols;
    assign tile.k_size        = k_size;

    assign flushing = (state == FLUSH);
    assign finished = flush_done && last_tile;    // Last flush cycle of the job

endmodule

//--- hdl/tile_if.sv
`timescale 1ns/1ps

interface tile_if;
    import gemm_pkg::*;

    logic       job_load;       // Idle to compute
    logic       tile_load;      // Any edge into compute, job_load included
    logic       flush_enter;    // Last compute cycle of a tile
    logic       flush_step;     // Flush cycle that stays in flush
    logic       row_wrap;       // Next tile opens a new tile row

    logic       computing;
    phase_cnt_t compute_count;

    tile_row_t  tile_row_id;
    tile_col_t  tile_col_id;
    tile_row_t  num_tile_rows;
    tile_col_t  num_tile_cols;
    k_size_t    k_size;

    modport seq (
        output job_load, tile_load, flush_enter, flush_step, row_wrap,
        output computing, compute_count,
        output tile_row_id, tile_col_id, num_tile_rows, num_tile_cols, k_size
    );

    modport addr (
        input job_load, tile_load, flush_enter, flush_step, row_wrap, computing,
        input tile_row_id, tile_col_id, num_tile_rows, num_tile_cols
    );

    modport lanes (
        input computing, flush_enter, compute_count, k_size
    );

endinterface

//--- hdl/gemm_pkg.sv
`include "gemm_defines.svh"

package gemm_pkg;

    // Job dimensions
    typedef logic [`MAX_M_LOG2-1:0] m_size_t;
    typedef logic [`MAX_K_LOG2-1:0] k_size_t;
    typedef logic [`MAX_N_LOG2-1:0] n_size_t;

    // Tile index or tile count, one spare bit so a full count fits
    typedef logic [`MAX_M_LOG2-`PE_ROWS_LOG2:0] tile_row_t;
    typedef logic [`MAX_N_LOG2-`PE_COLS_LOG2:0] tile_col_t;

    typedef logic [`PE_ROWS_LOG2:0] actv_row_t;    // 0 .. PE_ROWS
    typedef logic [`PE_COLS_LOG2:0] actv_col_t;    // 0 .. PE_COLS

    typedef logic [`MAX_K_LOG2+1:0] phase_cnt_t;   // Holds K + ar + ac

    typedef logic [`OPND1_AWIDTH-1:0] opnd1_addr_t;
    typedef logic [`OPND2_AWIDTH-1:0] opnd2_addr_t;
    typedef logic [`OUT_AWIDTH-1:0]   out_addr_t;

    // Ceiling of size / 2**dim_log2
    function automatic int unsigned tiles_needed(input int unsigned size,
                                                 input int unsigned dim_log2);
        int unsigned dim;
        dim = 1 << dim_log2;
        return (size + dim - 1) >> dim_log2;
    endfunction

endpackage

//--- include/gemm_defines.svh
`ifndef GEMM_DEFINES_SVH
`define GEMM_DEFINES_SVH

// PE array geometry
`define PE_ROWS         4
`define PE_COLS         4
`define PE_ROWS_LOG2    2
`define PE_COLS_LOG2    2

// Widths of the matrix size fields
`define MAX_M_LOG2      6
`define MAX_K_LOG2      6
`define MAX_N_LOG2      6

// SRAM address widths
`define OPND1_AWIDTH    8
`define OPND2_AWIDTH    8
`define OUT_AWIDTH      8

`endif
